//--- list.f
src/alu_pkg.sv
src/wb_pkg.sv
src/alu.sv
src/alu_regs.sv
src/alu_wb_top.sv
bench/tb_alu_wb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ALU peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_alu_wb -o Vtb_alu_wb
./obj_dir/Vtb_alu_wb | tee sim.log

if grep -q "^test passed$" sim.log; then
    exit 0
fi
exit 1

//--- bench/tb_alu_wb.sv
// ############################
// Testbench for the Wishbone ALU
// ############################
`timescale 1ns/10ps
`default_nettype none

module tb_alu_wb
    import alu_pkg::*;
    import wb_pkg::*;
    ();

    localparam int        WIDTH        = 8;
    localparam alu_word_t MASK         = alu_word_t'((1 << WIDTH) - 1);
    localparam int        ACK_TIMEOUT  = 20;    // Cycles per bus access
    localparam int        POLL_TIMEOUT = 20;    // Status reads per op

    logic        clock;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          tests;
    int          test_err0;                     // Errors at test start
    alu_op_t     op_list [8] = '{OP_ADD, OP_SUB, OP_AND, OP_OR,
                                 OP_XOR, OP_SRA, OP_SRL, OP_NOR};
    int          amounts [4] = '{0, 7, 8, 200}; // Shift amounts

    alu_wb_top #(
        .ALU_WIDTH (WIDTH)
    ) UUT (
        .i_clock (clock),
        .i_reset (reset),
        .i_wb    (wb_req),
        .o_wb    (wb_rsp)
    );

    always #10 clock = ~clock;                  // 20 ns period

    task abort_run(input string why);
        $display("%s", why);
        $display("Checks: %0d, errors: %0d, tests: %0d", checks, errors + 1, tests);
        $display("test failed");
        $finish;
    endtask

    // One classic access, started and sampled on falling edges
    task bus_cycle(input logic write, input wb_addr_t adr, input wb_data_t wdat,
                   output wb_data_t rdat);
        int count;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat: wdat};
        count  = 0;
        do
        begin
            @(negedge clock);
            count++;
        end
        while (!wb_rsp.ack && count < ACK_TIMEOUT);
        if (!wb_rsp.ack)
            abort_run($sformatf("No ack from the slave for address %0d", adr));
        rdat   = wb_rsp.dat;                    // Read data valid with ack
        wb_req = '0;
    endtask

    task write_reg(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task read_reg(input wb_addr_t adr, output wb_data_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    task wait_done(output wb_data_t stat);
        int polls;
        polls = 0;
        stat  = '0;
        while (!stat[STAT_DONE] && polls < POLL_TIMEOUT)
        begin
            read_reg(REG_STATUS, stat);
            polls++;
        end
        if (!stat[STAT_DONE])
            abort_run("The done bit never came up in the status register");
    endtask

    // Taps 32, 22, 2, 1
    function logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task rand_word(input int nbits, output alu_word_t v);
        v = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};          // One step per bit
        end
    endtask

    function int to_signed(input alu_word_t v);
        int r;
        r = int'(v & MASK);
        if (v[WIDTH-1])
            r = r - (1 << WIDTH);
        return r;
    endfunction

    // Expected result and flags, from integer arithmetic
    function void ref_alu(input alu_word_t a, input alu_word_t b,
                          input logic [ALU_OP_W-1:0] op,
                          output alu_word_t res, output alu_flags_t fl);
        int        sa;
        int        sb;
        int        full;                        // Unbounded sum or difference
        logic      legal;
        alu_word_t bm;
        sa    = to_signed(a);
        sb    = to_signed(b);
        bm    = b & MASK;
        res   = '0;
        fl    = '0;
        legal = 1'b1;
        case (op)
            OP_ADD, OP_SUB:
            begin
                full   = (op == OP_ADD) ? sa + sb : sa - sb;
                fl.ovf = full > (1 << (WIDTH - 1)) - 1 || full < -(1 << (WIDTH - 1));
                res    = alu_word_t'(full) & MASK;
            end
            OP_AND: res = a & b & MASK;
            OP_OR:  res = (a | b) & MASK;
            OP_XOR: res = (a ^ b) & MASK;
            OP_NOR: res = ~(a | b) & MASK;
            OP_SRL: res = (bm >= WIDTH) ? '0 : (a & MASK) >> bm;
            OP_SRA:
            begin
                if (bm >= WIDTH)
                    res = (sa < 0) ? MASK : '0; // All sign bits
                else
                    res = alu_word_t'(sa >>> bm) & MASK;
            end
            default: legal = 1'b0;
        endcase
        fl.illegal = !legal;
        fl.zero    = legal && (res == '0);
    endfunction

    function alu_flags_t status_flags(input wb_data_t s);
        alu_flags_t f;
        f.ovf     = s[STAT_OVF];
        f.zero    = s[STAT_ZERO];
        f.illegal = s[STAT_ILLEGAL];
        return f;
    endfunction

    task check_result(input alu_word_t got, input alu_word_t exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %0t: %s result %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task check_flags(input alu_flags_t got, input alu_flags_t exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %0t: %s flags %b, expected %b", $time, msg, got, exp);
        end
    endtask

    task check_data(input wb_data_t got, input wb_data_t exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %0t: %s read %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // Full operation over the bus, then compare with the model
    task run_and_check(input alu_word_t a, input alu_word_t b,
                       input logic [ALU_OP_W-1:0] op, input string tag);
        wb_data_t   stat;
        wb_data_t   got;
        alu_word_t  exp_res;
        alu_flags_t exp_fl;
        write_reg(REG_A, a);
        write_reg(REG_B, b);
        write_reg(REG_OP, wb_data_t'(op));      // Starts the ALU
        wait_done(stat);
        read_reg(REG_RESULT, got);
        ref_alu(a, b, op, exp_res, exp_fl);
        check_result(got, exp_res, $sformatf("%s op %h a %h b %h", tag, op, a, b));
        check_flags(status_flags(stat), exp_fl, $sformatf("%s op %h a %h b %h", tag, op, a, b));
    endtask

    task end_test(input string name);
        tests++;
        if (errors == test_err0)
            $display("Test %0d %s: ok", tests, name);
        else
            $display("Test %0d %s: %0d errors", tests, name, errors - test_err0);
        test_err0 = errors;
    endtask

    initial
    begin
        wb_data_t  rd;
        alu_word_t a;
        alu_word_t b;
        clock     = 1'b0;
        reset     = 1'b1;
        wb_req    = '0;
        lfsr      = 32'ha797;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_err0 = 0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        for (int adr = 0; adr < 8; adr++)       // Unmapped 5..7 included
        begin
            read_reg(wb_addr_t'(adr), rd);
            check_data(rd, (wb_addr_t'(adr) == REG_OP) ? wb_data_t'(OP_ADD) : '0,
                       $sformatf("reset value at %0d", adr));
        end
        end_test("reset values");

        for (int k = 0; k < 8; k++)
        begin
            for (int n = 0; n < 40; n++)
            begin
                rand_word(ALU_WORD_W, a);       // Full word, DUT masks to 8 bits
                rand_word(ALU_WORD_W, b);
                run_and_check(a, b, op_list[k], "random");
            end
        end
        end_test("random operands");

        run_and_check(32'h7F, 32'h01, OP_ADD, "127+1");
        run_and_check(32'h80, 32'h01, OP_SUB, "-128-1");
        run_and_check(32'h80, 32'hFF, OP_ADD, "-128+-1");
        run_and_check(32'h7F, 32'hFF, OP_SUB, "127--1");
        run_and_check(32'h55, 32'h55, OP_SUB, "equal sub");
        end_test("add and sub corners");

        for (int i = 0; i < 4; i++)
        begin
            run_and_check(32'h96, alu_word_t'(amounts[i]), OP_SRA, "sra neg");
            run_and_check(32'h35, alu_word_t'(amounts[i]), OP_SRA, "sra pos");
            run_and_check(32'h96, alu_word_t'(amounts[i]), OP_SRL, "srl neg");
            run_and_check(32'h35, alu_word_t'(amounts[i]), OP_SRL, "srl pos");
        end
        end_test("shift amounts");

        run_and_check(32'h12, 32'h34, 6'h3F, "illegal");
        run_and_check(32'h03, 32'h04, OP_ADD, "legal after illegal");
        end_test("illegal code");

        run_and_check(32'h05, 32'h03, OP_XOR, "before ignored writes");
        read_reg(REG_STATUS, rd);
        check_data(rd, 32'h1, "status after xor");
        write_reg(REG_RESULT, 32'hFFFF_FFFF);
        write_reg(REG_STATUS, 32'hFFFF_FFFF);
        write_reg(3'd6, 32'hA5A5_A5A5);         // Unmapped
        read_reg(REG_RESULT, rd);
        check_data(rd, 32'h06, "result after ignored write");  // 5 xor 3
        read_reg(REG_STATUS, rd);
        check_data(rd, 32'h1, "status after ignored write");
        read_reg(3'd6, rd);
        check_data(rd, '0, "unmapped address");
        read_reg(REG_A, rd);
        check_data(rd, 32'h05, "operand A kept");
        write_reg(REG_B, 32'h05);
        write_reg(REG_OP, wb_data_t'(OP_SUB));  // 5 - 5, zero expected
        read_reg(REG_STATUS, rd);
        // A done seen this early must already belong to the new op
        if (rd[STAT_DONE] !== 1'b0)
            check_data(rd, 32'h5, "status right after op write");
        wait_done(rd);
        check_data(rd, 32'h5, "status after new op");  // Done and zero
        end_test("ignored writes and status");

        $display("Checks: %0d, errors: %0d, tests: %0d", checks, errors, tests);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/alu_wb_top.sv
// ############################
// ALU peripheral top, bus in
// ############################
`timescale 1ns/10ps
`default_nettype none

module alu_wb_top
    import alu_pkg::*;
    import wb_pkg::*;
    #(
        parameter int ALU_WIDTH = 8                 // Operand width, 4 to 32
    )
    (
        input  wire logic    i_clock,
        input  wire logic    i_reset,
        input  wire wb_req_t i_wb,                  // From bus master
        output wb_rsp_t      o_wb
    );

    alu_req_t alu_req;                              // Regs to ALU
    alu_rsp_t alu_rsp;                              // ALU back to regs

    // Bus decode and register file
    alu_regs #(
        .ALU_WIDTH (ALU_WIDTH)
    ) u_regs (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_wb      (i_wb),
        .o_wb      (o_wb),
        .o_alu_req (alu_req),
        .i_alu_rsp (alu_rsp)
    );

    // Registered datapath
    alu #(
        .ALU_WIDTH (ALU_WIDTH)
    ) u_alu (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_alu_req (alu_req),
        .o_alu_rsp (alu_rsp)
    );

endmodule

`default_nettype wire

//--- src/alu_regs.sv
// ############################
// Wishbone slave: operand and op
// registers, result and status
// ############################
`timescale 1ns/10ps
`default_nettype none

module alu_regs
    import alu_pkg::*;
    import wb_pkg::*;
    #(
        parameter int ALU_WIDTH = 8                 // From the top level
    )
    (
        input  wire logic     i_clock,
        input  wire logic     i_reset,
        input  wire wb_req_t  i_wb,
        output wb_rsp_t       o_wb,
        output alu_req_t      o_alu_req,
        input  wire alu_rsp_t i_alu_rsp
    );

    // Low ALU_WIDTH bits set
    localparam alu_word_t WIDTH_MASK =
        alu_word_t'({ALU_WORD_W{1'b1}} >> (ALU_WORD_W - ALU_WIDTH));

    logic       access;                             // New cycle sampled this clock
    logic       wr_en;
    logic       op_start;                           // Write to REG_OP
    wb_data_t   rd_mux;

    logic       ack_q;
    logic       start_q;
    wb_data_t   rdata_q;
    alu_word_t  a_q;
    alu_word_t  b_q;
    alu_op_t    op_q;
    alu_word_t  result_q;                           // Last captured result
    alu_flags_t flags_q;
    logic       done_q;                             // Sticky until next op write

    // Ack low gates a second sample of the same access
    assign access   = i_wb.cyc && i_wb.stb && !ack_q;
    assign wr_en    = access && i_wb.we;
    assign op_start = wr_en && (i_wb.adr == REG_OP);

    // Address map for reads
    always_comb
    begin
        rd_mux = '0;                                // Unmapped reads as 0
        case (i_wb.adr)
            REG_A:      rd_mux = a_q;
            REG_B:      rd_mux = b_q;
            REG_OP:     rd_mux = wb_data_t'(op_q);
            REG_RESULT: rd_mux = result_q;
            REG_STATUS:
            begin
                rd_mux[STAT_DONE]    = done_q;
                rd_mux[STAT_OVF]     = flags_q.ovf;
                rd_mux[STAT_ZERO]    = flags_q.zero;
                rd_mux[STAT_ILLEGAL] = flags_q.illegal;
            end
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            ack_q    <= 1'b0;
            start_q  <= 1'b0;
            a_q      <= '0;
            b_q      <= '0;
            op_q     <= OP_ADD;                     // Reset op is ADD
            result_q <= '0;
            flags_q  <= '0;
            done_q   <= 1'b0;
        end
        else
        begin
            ack_q   <= access;                      // One-cycle ack
            start_q <= op_start;                    // High in the ack cycle
            if (wr_en)
            begin
                case (i_wb.adr)
                    REG_A:   a_q  <= i_wb.dat;
                    REG_B:   b_q  <= i_wb.dat;
                    REG_OP:  op_q <= alu_op_t'(i_wb.dat[ALU_OP_W-1:0]);
                    default: ;                      // Read-only or unmapped, ignored
                endcase
            end
            // ALU answer
            if (i_alu_rsp.done)
            begin
                result_q <= i_alu_rsp.result;
                flags_q  <= i_alu_rsp.flags;
                done_q   <= 1'b1;
            end
            if (op_start)
                done_q <= 1'b0;                     // New op wins over late done
        end
    end

    // Read data, zero on write acks
    always_ff @(posedge i_clock)
    begin
        rdata_q <= (access && !i_wb.we) ? rd_mux : '0;
    end

    assign o_wb = '{ack: ack_q, dat: rdata_q};

    assign o_alu_req = '{
        a:     a_q & WIDTH_MASK,                    // Masked to ALU width
        b:     b_q & WIDTH_MASK,
        op:    op_q,
        start: start_q
    };

endmodule

`default_nettype wire

//--- src/alu.sv
// ############################
// Registered ALU, MIPS funct ops
// ############################
`timescale 1ns/10ps
`default_nettype none

module alu
    import alu_pkg::*;
    #(
        parameter int ALU_WIDTH = 8                 // Operand width, 4 to 32
    )
    (
        input  wire logic     i_clock,
        input  wire logic     i_reset,
        input  wire alu_req_t i_alu_req,
        output alu_rsp_t      o_alu_rsp
    );

    localparam int MSB = ALU_WIDTH - 1;

    logic [MSB:0] a_w;                              // Operands at ALU width
    logic [MSB:0] b_w;
    logic [MSB:0] res_w;                            // Combinational result
    alu_word_t    res_ext;                          // Zero-extended to bus word
    alu_flags_t   flags_c;

    alu_word_t    result_q;
    alu_flags_t   flags_q;
    logic         done_q;

    assign a_w = i_alu_req.a[MSB:0];
    assign b_w = i_alu_req.b[MSB:0];

    always_comb
    begin
        res_w           = '0;
        flags_c.ovf     = 1'b0;
        flags_c.illegal = 1'b0;
        case (i_alu_req.op)
            OP_ADD:
            begin
                res_w       = a_w + b_w;
                // Same-sign operands, result flips away from A
                flags_c.ovf = (a_w[MSB] == b_w[MSB]) && (res_w[MSB] != a_w[MSB]);
            end
            OP_SUB:
            begin
                res_w       = a_w - b_w;
                // Opposite-sign operands, result flips away from A
                flags_c.ovf = (a_w[MSB] != b_w[MSB]) && (res_w[MSB] != a_w[MSB]);
            end
            OP_AND: res_w = a_w & b_w;
            OP_OR:  res_w = a_w | b_w;
            OP_XOR: res_w = a_w ^ b_w;
            OP_NOR: res_w = ~(a_w | b_w);
            // Full B is the amount, large shifts saturate
            OP_SRA: res_w = $signed(a_w) >>> i_alu_req.b;   // Sign fill past width
            OP_SRL: res_w = a_w >> i_alu_req.b;             // Zero past width
            default:
            begin
                flags_c.illegal = 1'b1;             // Result stays 0
            end
        endcase
        // Zero only meaningful for legal codes
        flags_c.zero = !flags_c.illegal && (res_w == '0);
    end

    always_comb
    begin
        res_ext          = '0;
        res_ext[MSB:0]   = res_w;
    end

    // Done is control, cleared by reset
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            done_q <= 1'b0;
        else
            done_q <= i_alu_req.start;              // One clock after start
    end

    // Result and flags only load on start
    always_ff @(posedge i_clock)
    begin
        if (i_alu_req.start)
        begin
            result_q <= res_ext;
            flags_q  <= flags_c;
        end
    end

    assign o_alu_rsp = '{result: result_q, flags: flags_q, done: done_q};

endmodule

`default_nettype wire

//--- src/wb_pkg.sv
// ############################
// Wishbone classic structs and
// the peripheral register map
// ############################
`default_nettype none

package wb_pkg;

    localparam int WB_ADDR_W = 3;                   // Word address
    localparam int WB_DATA_W = 32;

    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;

    // Master side
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;                               // 1 = write
        wb_addr_t adr;
        wb_data_t dat;                              // Write data
    } wb_req_t;

    // Slave side
    typedef struct packed {
        logic     ack;                              // Single-cycle, registered
        wb_data_t dat;                              // Read data
    } wb_rsp_t;

    // Register map
    localparam wb_addr_t REG_A      = 3'd0;
    localparam wb_addr_t REG_B      = 3'd1;
    localparam wb_addr_t REG_OP     = 3'd2;         // Write starts an operation
    localparam wb_addr_t REG_RESULT = 3'd3;         // Read only
    localparam wb_addr_t REG_STATUS = 3'd4;         // Read only

    // Status bit positions
    localparam int STAT_DONE    = 0;
    localparam int STAT_OVF     = 1;
    localparam int STAT_ZERO    = 2;
    localparam int STAT_ILLEGAL = 3;

endpackage

`default_nettype wire

//--- src/alu_pkg.sv
// ############################
// ALU types: operand words, MIPS
// function codes, flags, req/rsp
// ############################
`default_nettype none

package alu_pkg;

    localparam int ALU_WORD_W = 32;                 // Widest supported operand
    localparam int ALU_OP_W   = 6;                  // MIPS funct field

    // Operand and result word, narrow ALUs use the low bits
    typedef logic [ALU_WORD_W-1:0] alu_word_t;

    // Function codes as in the MIPS funct field
    typedef enum logic [ALU_OP_W-1:0] {
        OP_ADD = 6'b100000,                         // Signed add
        OP_SUB = 6'b100010,                         // Signed subtract
        OP_AND = 6'b100100,
        OP_OR  = 6'b100101,
        OP_XOR = 6'b100110,
        OP_SRA = 6'b000011,                         // Shift right arithmetic
        OP_SRL = 6'b000010,                         // Shift right logic
        OP_NOR = 6'b100111
    } alu_op_t;

    typedef struct packed {
        logic ovf;                                  // ADD/SUB only
        logic zero;                                 // Result is 0, legal ops
        logic illegal;                              // Unknown function code
    } alu_flags_t;

    // Request from the register block
    typedef struct packed {
        alu_word_t a;
        alu_word_t b;
        alu_op_t   op;
        logic      start;                           // One-cycle pulse
    } alu_req_t;

    // Answer one clock after start
    typedef struct packed {
        alu_word_t  result;
        alu_flags_t flags;
        logic       done;                           // One-cycle pulse
    } alu_rsp_t;

endpackage

`default_nettype wire
